// ==== hw/accel_consts.svh ====
`ifndef ACCEL_CONSTS_SVH
`define ACCEL_CONSTS_SVH

// pixel lanes carried by one beat
`define ACCEL_UNITS 4

// pixel, weight and output word width
`define ACCEL_WORD_W 8

// accumulator width, headroom for 63 taps of 8x8 products
`define ACCEL_ACC_W 24

// width of cfg_taps, legal range 1..63
`define ACCEL_TAPS_W 6

// negative slope of leaky relu, alpha = 1/8
`define ACCEL_LRELU_SHIFT 3

`endif

// ==== hw/accel_pkg.sv ====
`default_nettype none

`include "accel_consts.svh"

package accel_pkg;

  // signed pixel / weight / output word
  typedef logic signed [`ACCEL_WORD_W-1:0] word_t;

  // signed accumulator
  typedef logic signed [`ACCEL_ACC_W-1:0] acc_t;

  // lane 0 sits in the low bits
  typedef word_t [`ACCEL_UNITS-1:0] pix_vec_t;
  typedef acc_t [`ACCEL_UNITS-1:0] acc_vec_t;

  // pixels and shared weight after the join
  typedef struct packed {
    pix_vec_t pix;
    word_t    wgt;
  } joined_beat_t;

  // position of the popped tap within its run
  typedef enum logic [2:0] {
    MAC_IDLE,
    MAC_START,
    MAC_ACCUM,
    MAC_END,
    MAC_ONLY
  } mac_op_e;

  // hold = finished result waiting for the output stage
  typedef enum logic {
    SEQ_RUN,
    SEQ_HOLD
  } seq_state_e;

endpackage

`default_nettype wire

// ==== hw/conv_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_sequencer (
  input  wire                aclk,
  input  wire                rst,
  input  wire                beat_valid,
  output logic               pop,
  input  wire                first_tap,
  input  wire                last_tap,
  output accel_pkg::mac_op_e mac_op,
  output logic               res_valid,
  input  wire                res_ready
);

  import accel_pkg::*;

  seq_state_e state;

  // a finished result waits for the output stage
  assign res_valid = (state == SEQ_HOLD);

  // a last tap would overwrite the held result
  // unless it leaves on this same edge
  assign pop = beat_valid && (!last_tap || !res_valid || res_ready);

  // tap position of the popped beat
  always_comb begin
    if (!pop) begin
      mac_op = MAC_IDLE;
    end else begin
      case ({first_tap, last_tap})
        2'b10:   mac_op = MAC_START;
        2'b00:   mac_op = MAC_ACCUM;
        2'b01:   mac_op = MAC_END;
        default: mac_op = MAC_ONLY;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      state <= SEQ_RUN;
    end else begin
      case (state)
        SEQ_RUN: begin
          if (pop && last_tap) begin
            state <= SEQ_HOLD;
          end
        end
        default: begin
          // handoff done, stay held if a new result lands now
          if (res_ready && !(pop && last_tap)) begin
            state <= SEQ_RUN;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/conv_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "accel_consts.svh"

module conv_top (
  input  wire                      aclk,
  input  wire                      rst,
  input  wire [`ACCEL_TAPS_W-1:0]  cfg_taps,
  input  wire                      s_pix_valid,
  output wire                      s_pix_ready,
  input  wire accel_pkg::pix_vec_t s_pix_data,
  input  wire                      s_wgt_valid,
  output wire                      s_wgt_ready,
  input  wire accel_pkg::word_t    s_wgt_data,
  output wire                      m_valid,
  input  wire                      m_ready,
  output wire accel_pkg::pix_vec_t m_data
);

  import accel_pkg::*;

  // joined beat towards the sequencer and the lanes
  logic         beat_valid;
  joined_beat_t beat;
  // one pop also steps the tap counter
  logic         pop;
  logic         first_tap;
  logic         last_tap;
  mac_op_e      mac_op;
  // accumulator result handoff
  logic         res_valid;
  logic         res_ready;
  acc_vec_t     result;

  input_pipe input_pipe_inst (
    .aclk        (aclk       ),
    .rst         (rst        ),
    .s_pix_valid (s_pix_valid),
    .s_pix_ready (s_pix_ready),
    .s_pix_data  (s_pix_data ),
    .s_wgt_valid (s_wgt_valid),
    .s_wgt_ready (s_wgt_ready),
    .s_wgt_data  (s_wgt_data ),
    .beat_valid  (beat_valid ),
    .beat        (beat       ),
    .pop         (pop        )
  );

  tap_counter tap_counter_inst (
    .aclk      (aclk     ),
    .rst       (rst      ),
    .step      (pop      ),
    .cfg_taps  (cfg_taps ),
    .first_tap (first_tap),
    .last_tap  (last_tap )
  );

  conv_sequencer conv_sequencer_inst (
    .aclk       (aclk      ),
    .rst        (rst       ),
    .beat_valid (beat_valid),
    .pop        (pop       ),
    .first_tap  (first_tap ),
    .last_tap   (last_tap  ),
    .mac_op     (mac_op    ),
    .res_valid  (res_valid ),
    .res_ready  (res_ready )
  );

  mac_array mac_array_inst (
    .aclk   (aclk  ),
    .rst    (rst   ),
    .mac_op (mac_op),
    .beat   (beat  ),
    .result (result)
  );

  lrelu_stage lrelu_stage_inst (
    .aclk      (aclk     ),
    .rst       (rst      ),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .result    (result   ),
    .m_valid   (m_valid  ),
    .m_ready   (m_ready  ),
    .m_data    (m_data   )
  );

endmodule

`default_nettype wire

// ==== hw/input_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_pipe (
  input  wire                      aclk,
  input  wire                      rst,
  input  wire                      s_pix_valid,
  output logic                     s_pix_ready,
  input  wire accel_pkg::pix_vec_t s_pix_data,
  input  wire                      s_wgt_valid,
  output logic                     s_wgt_ready,
  input  wire accel_pkg::word_t    s_wgt_data,
  output logic                     beat_valid,
  output accel_pkg::joined_beat_t  beat,
  input  wire                      pop
);

  // both streams move together or not at all
  logic take;

  // slot is free when empty or drained this cycle
  assign take = s_pix_valid && s_wgt_valid && (!beat_valid || pop);

  // same decision on both sides of the join
  assign s_pix_ready = take;
  assign s_wgt_ready = take;

  // occupancy of the single beat register
  always_ff @(posedge aclk) begin
    if (rst) begin
      beat_valid <= 1'b0;
    end else if (take) begin
      // refill, possibly in the same cycle as a pop
      beat_valid <= 1'b1;
    end else if (pop) begin
      beat_valid <= 1'b0;
    end
  end

  // payload only
  always_ff @(posedge aclk) begin
    if (take) begin
      beat.pix <= s_pix_data;
      beat.wgt <= s_wgt_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/lrelu_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "accel_consts.svh"

module lrelu_stage (
  input  wire                      aclk,
  input  wire                      rst,
  input  wire                      res_valid,
  output logic                     res_ready,
  input  wire accel_pkg::acc_vec_t result,
  output logic                     m_valid,
  input  wire                      m_ready,
  output accel_pkg::pix_vec_t      m_data
);

  import accel_pkg::*;

  // clamp bounds of the output word
  localparam word_t word_max = {1'b0, {(`ACCEL_WORD_W-1){1'b1}}};
  localparam word_t word_min = {1'b1, {(`ACCEL_WORD_W-1){1'b0}}};

  // after the leaky slope, before clamping
  acc_vec_t act;
  pix_vec_t sat;

  always_comb begin
    for (int i = 0; i < `ACCEL_UNITS; i++) begin
      // negative side scaled by 1/8
      if (result[i][`ACCEL_ACC_W-1]) begin
        act[i] = $signed(result[i]) >>> `ACCEL_LRELU_SHIFT;
      end else begin
        act[i] = result[i];
      end
      if ($signed(act[i]) > acc_t'(word_max)) begin
        sat[i] = word_max;
      end else if ($signed(act[i]) < acc_t'(word_min)) begin
        sat[i] = word_min;
      end else begin
        sat[i] = act[i][`ACCEL_WORD_W-1:0];
      end
    end
  end

  // free when empty or drained this cycle
  assign res_ready = !m_valid || m_ready;

  always_ff @(posedge aclk) begin
    if (rst) begin
      m_valid <= 1'b0;
    end else if (res_ready) begin
      m_valid <= res_valid;
    end
  end

  // output word held while m_ready is low
  always_ff @(posedge aclk) begin
    if (res_valid && res_ready) begin
      m_data <= sat;
    end
  end

endmodule

`default_nettype wire

// ==== hw/mac_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "accel_consts.svh"

module mac_array (
  input  wire                     aclk,
  input  wire                     rst,
  input  wire accel_pkg::mac_op_e mac_op,
  input  wire accel_pkg::joined_beat_t beat,
  output accel_pkg::acc_vec_t     result
);

  import accel_pkg::*;

  // running sums, one per lane
  acc_vec_t acc;
  // this tap's product per lane
  acc_vec_t prod;
  // running sum plus this tap
  acc_vec_t sum;

  // signed 8x8, sign extended to accumulator width
  always_comb begin
    for (int i = 0; i < `ACCEL_UNITS; i++) begin
      prod[i] = $signed(beat.pix[i]) * $signed(beat.wgt);
      sum[i]  = acc[i] + prod[i];
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      acc <= '0;
    end else begin
      case (mac_op)
        MAC_START: acc <= prod;
        MAC_ACCUM: acc <= sum;
        // run closed, ready for the next one
        MAC_END,
        MAC_ONLY:  acc <= '0;
        default:   acc <= acc;
      endcase
    end
  end

  // result register, loads on the closing tap
  always_ff @(posedge aclk) begin
    if (mac_op == MAC_END) begin
      result <= sum;
    end else if (mac_op == MAC_ONLY) begin
      // single tap, no history to add
      result <= prod;
    end
  end

endmodule

`default_nettype wire

// ==== hw/tap_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "accel_consts.svh"

module tap_counter (
  input  wire                     aclk,
  input  wire                     rst,
  input  wire                     step,
  input  wire [`ACCEL_TAPS_W-1:0] cfg_taps,
  output logic                    first_tap,
  output logic                    last_tap
);

  // index of the offered tap inside its run
  logic [`ACCEL_TAPS_W-1:0] tap_idx;
  // run length minus one, captured at the first tap
  logic [`ACCEL_TAPS_W-1:0] run_last;
  // index of the final tap for the current run
  logic [`ACCEL_TAPS_W-1:0] last_idx;

  assign first_tap = (tap_idx == '0);

  // on the first tap the latch is not loaded yet, look at the port
  assign last_idx = first_tap ? cfg_taps - 1'b1 : run_last;
  assign last_tap = (tap_idx == last_idx);

  always_ff @(posedge aclk) begin
    if (rst) begin
      tap_idx  <= '0;
      run_last <= '0;
    end else if (step) begin
      if (first_tap) begin
        run_last <= cfg_taps - 1'b1;
      end
      // wrap to zero after the last tap of a run
      if (last_tap) begin
        tap_idx <= '0;
      end else begin
        tap_idx <= tap_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/accel_pkg.sv
hw/input_pipe.sv
hw/tap_counter.sv
hw/conv_sequencer.sv
hw/mac_array.sv
hw/lrelu_stage.sv
hw/conv_top.sv
sim/tb_clock.sv
sim/tb_conv_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the conv_top testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f project.f --top-module tb_conv_top -o tb_conv_top &&
./obj_dir/tb_conv_top || exit 1

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

// free running testbench clock, 20 ns period
module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== sim/tb_conv_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "accel_consts.svh"

module tb_conv_top;

  import accel_pkg::*;

  // tests need about 4000 cycles, limit at roughly five times that
  localparam int timeout_cycles = 20000;
  // longest wait for the last words of a test
  localparam int drain_cycles = 200;

  logic                     aclk;
  logic                     rst;
  logic [`ACCEL_TAPS_W-1:0] cfg_taps;
  logic                     s_pix_valid;
  logic                     s_pix_ready;
  pix_vec_t                 s_pix_data;
  logic                     s_wgt_valid;
  logic                     s_wgt_ready;
  word_t                    s_wgt_data;
  logic                     m_valid;
  logic                     m_ready = 1'b0;
  pix_vec_t                 m_data;

  int         seed;
  int         cycle_cnt = 0;
  // expected output words, oldest first
  pix_vec_t   exp_q [$];
  // taps of the run being sent
  pix_vec_t   run_pix [0:63];
  word_t      run_wgt [0:63];
  // output back-pressure pattern, used only in the random test
  logic       ready_rand = 1'b0;
  logic       ready_pat [0:1023];
  logic [9:0] ready_idx = '0;

  tb_clock tb_clock_inst (
    .clk (aclk)
  );

  conv_top conv_top_inst (
    .aclk        (aclk       ),
    .rst         (rst        ),
    .cfg_taps    (cfg_taps   ),
    .s_pix_valid (s_pix_valid),
    .s_pix_ready (s_pix_ready),
    .s_pix_data  (s_pix_data ),
    .s_wgt_valid (s_wgt_valid),
    .s_wgt_ready (s_wgt_ready),
    .s_wgt_data  (s_wgt_data ),
    .m_valid     (m_valid    ),
    .m_ready     (m_ready    ),
    .m_data      (m_data     )
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_val(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_run($sformatf("Fail at time %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  // leaky relu with alpha 1/8, then clamp to a signed byte
  function automatic int model_word(input int sum);
    int act;
    if (sum < 0) begin
      act = sum >>> 3;
    end else begin
      act = sum;
    end
    if (act > 127) begin
      act = 127;
    end else if (act < -128) begin
      act = -128;
    end
    return act;
  endfunction

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return r % n;
  endfunction

  // one expected word per lane from the taps in run_pix / run_wgt
  task automatic push_expected(input int taps);
    pix_vec_t exp_vec;
    word_t    px;
    int       sum;
    int       w;
    int       l;
    int       t;
    for (l = 0; l < `ACCEL_UNITS; l++) begin
      sum = 0;
      for (t = 0; t < taps; t++) begin
        px  = run_pix[t][l];
        sum = sum + int'(px) * int'(run_wgt[t]);
      end
      w          = model_word(sum);
      exp_vec[l] = w[7:0];
    end
    exp_q.push_back(exp_vec);
  endtask

  // both streams held until the joint transfer, each after its own gap
  task automatic send_beat(input pix_vec_t pix, input word_t wgt, input int pix_gap,
                           input int wgt_gap);
    int pg;
    int wg;
    int wgt_takes;
    bit moved;
    pg        = pix_gap;
    wg        = wgt_gap;
    wgt_takes = 0;
    moved     = 1'b0;
    while (!moved) begin
      if (pg == 0) begin
        s_pix_valid <= 1'b1;
        s_pix_data  <= pix;
      end else begin
        pg = pg - 1;
      end
      if (wg == 0) begin
        s_wgt_valid <= 1'b1;
        s_wgt_data  <= wgt;
      end else begin
        wg = wg - 1;
      end
      @(negedge aclk);
      // pixel handshake ends the wait
      moved = s_pix_valid && s_pix_ready;
      // weight handshakes counted on their own
      if (s_wgt_valid && s_wgt_ready) begin
        wgt_takes++;
      end
      @(posedge aclk);
    end
    s_pix_valid <= 1'b0;
    s_wgt_valid <= 1'b0;
    // one joined beat takes exactly one weight
    check_val("s_wgt_ready", wgt_takes, 1);
  endtask

  task automatic send_run(input int taps, input int max_gap);
    int t;
    int pg;
    int wg;
    push_expected(taps);
    for (t = 0; t < taps; t++) begin
      pg = 0;
      wg = 0;
      if (max_gap > 0) begin
        pg = rand_below(max_gap + 1);
        wg = rand_below(max_gap + 1);
      end
      send_beat(run_pix[t], run_wgt[t], pg, wg);
      // first tap is in, previous run no longer reads cfg_taps
      if (t == 0) begin
        cfg_taps <= taps[`ACCEL_TAPS_W-1:0];
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    // bounded, a lost word stays behind in the queue
    while (exp_q.size() != 0 && waited < drain_cycles) begin
      @(posedge aclk);
      waited++;
    end
    // quiet window, any extra word hits an empty queue
    repeat (8) @(posedge aclk);
  endtask

  task automatic test_reset();
    int i;
    for (i = 0; i < 4; i++) begin
      @(posedge aclk);
      if (i == 3) begin
        rst <= 1'b0;
      end
      @(negedge aclk);
      check_val("m_valid", int'(m_valid), 0);
    end
    @(posedge aclk);
    @(negedge aclk);
    check_val("m_valid", int'(m_valid), 0);
    @(posedge aclk);
  endtask

  task automatic test_three_taps();
    int r;
    int t;
    int l;
    int v;
    for (r = 0; r < 2; r++) begin
      for (t = 0; t < 3; t++) begin
        for (l = 0; l < `ACCEL_UNITS; l++) begin
          v             = (r == 0) ? t + l + 1 : 2 * l + t;
          run_pix[t][l] = v[7:0];
        end
        v          = (r == 0) ? ((t == 0) ? 2 : (t == 1) ? 3 : 1) : t + 1;
        run_wgt[t] = v[7:0];
      end
      send_run(3, 0);
    end
    wait_drain();
  endtask

  // cfg_taps 1, every beat closes its own run
  task automatic test_single_tap();
    int b;
    int l;
    int v;
    for (b = 0; b < 4; b++) begin
      for (l = 0; l < `ACCEL_UNITS; l++) begin
        v             = 9 * b - 6 * l + 3;
        run_pix[0][l] = v[7:0];
      end
      v          = 5 - 3 * b;
      run_wgt[0] = v[7:0];
      send_run(1, 0);
    end
    wait_drain();
  endtask

  task automatic test_lrelu_sat();
    // negative sums, slope by 1/8 with rounding toward minus infinity
    run_pix[0] = {8'sd5, -8'sd128, -8'sd100, -8'sd10};
    run_wgt[0] = 8'sd3;
    run_pix[1] = {8'sd7, -8'sd128, -8'sd2, -8'sd1};
    run_wgt[1] = 8'sd4;
    send_run(2, 0);
    // clamp at both ends
    run_pix[0] = {8'sd100, -8'sd128, -8'sd128, 8'sd127};
    run_wgt[0] = 8'sd127;
    send_run(1, 0);
    run_pix[0] = {8'sd0, -8'sd1, 8'sd64, -8'sd128};
    run_wgt[0] = -8'sd128;
    send_run(1, 0);
    wait_drain();
  endtask

  task automatic test_random_flow();
    int run;
    int taps;
    int t;
    int l;
    int r;
    @(negedge aclk);
    ready_rand = 1'b1;
    @(posedge aclk);
    for (run = 0; run < 40; run++) begin
      taps = 1 + rand_below(8);
      for (t = 0; t < taps; t++) begin
        for (l = 0; l < `ACCEL_UNITS; l++) begin
          r             = $random(seed);
          run_pix[t][l] = r[7:0];
        end
        // small weights keep part of the sums out of saturation
        r          = $random(seed) % 16;
        run_wgt[t] = r[7:0];
      end
      send_run(taps, 3);
    end
    wait_drain();
  endtask

  // scoreboard, sampled half a cycle before the transfer edge
  always @(negedge aclk) begin : out_monitor
    pix_vec_t exp_vec;
    word_t    got_w;
    word_t    exp_w;
    int       l;
    if (!rst && m_valid && m_ready) begin
      if (exp_q.size() == 0) begin
        fail_run("output word transferred while none was expected");
      end else begin
        exp_vec = exp_q.pop_front();
        for (l = 0; l < `ACCEL_UNITS; l++) begin
          got_w = m_data[l];
          exp_w = exp_vec[l];
          check_val($sformatf("m_data[%0d]", l), int'(got_w), int'(exp_w));
        end
      end
    end
  end

  // sink side, always ready outside the random test
  always @(posedge aclk) begin
    if (ready_rand) begin
      m_ready <= ready_pat[ready_idx];
    end else begin
      m_ready <= 1'b1;
    end
    ready_idx <= ready_idx + 1'b1;
  end

  always @(posedge aclk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      fail_run($sformatf("timeout, run not finished after %0d cycles", timeout_cycles));
    end
  end

  initial begin
    int i;
    seed        = 46;
    rst         = 1'b1;
    cfg_taps    = `ACCEL_TAPS_W'(1);
    s_pix_valid = 1'b0;
    s_pix_data  = '0;
    s_wgt_valid = 1'b0;
    s_wgt_data  = '0;
    // about two thirds of the cycles ready
    for (i = 0; i < 1024; i++) begin
      ready_pat[i] = (rand_below(3) != 0);
    end
    test_reset();
    test_three_taps();
    test_single_tap();
    test_lrelu_sat();
    test_random_flow();
    if (exp_q.size() != 0) begin
      fail_run($sformatf("%0d expected output words never arrived", exp_q.size()));
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

`default_nettype wire
